//--- design/sp_decode.sv
`timescale 1ns/100ps

module sp_decode (
	input  sp_isa_pkg::opcode_t    op,
	input  logic [sp_isa_pkg::FMT_W-1:0] format,
	input  logic                   branch_taken,
	output sp_isa_pkg::sp_op_e     op_kind
);

	logic is_nop;

	assign is_nop = (format == sp_isa_pkg::FMT_RR) && (op[0:9] == '0);

	always_comb begin
		op_kind = sp_isa_pkg::OP_NONE;
		if (!is_nop && !branch_taken) begin
			case (format)
				sp_isa_pkg::FMT_RR: begin
					case (op)
						sp_isa_pkg::OPC_MPY:  op_kind = sp_isa_pkg::OP_MPY;
						sp_isa_pkg::OPC_MPYU: op_kind = sp_isa_pkg::OP_MPYU;
						sp_isa_pkg::OPC_MPYH: op_kind = sp_isa_pkg::OP_MPYH;
						sp_isa_pkg::OPC_FCEQ: op_kind = sp_isa_pkg::OP_FCEQ;
						sp_isa_pkg::OPC_FCGT: op_kind = sp_isa_pkg::OP_FCGT;
						default:              op_kind = sp_isa_pkg::OP_NONE;
					endcase
				end
				sp_isa_pkg::FMT_RRR: begin
					if (op[7:10] == sp_isa_pkg::OPC_MPYA) begin
						op_kind = sp_isa_pkg::OP_MPYA;
					end
				end
				sp_isa_pkg::FMT_RI8: begin
					op_kind = sp_isa_pkg::OP_NONE;   // Only float conversions live here
				end
				sp_isa_pkg::FMT_RI10: begin
					case (op[3:10])
						sp_isa_pkg::OPC_MPYI:  op_kind = sp_isa_pkg::OP_MPYI;
						sp_isa_pkg::OPC_MPYUI: op_kind = sp_isa_pkg::OP_MPYUI;
						default:               op_kind = sp_isa_pkg::OP_NONE;
					endcase
				end
				default: begin
					op_kind = sp_isa_pkg::OP_NONE;
				end
			endcase
		end
	end

	op_kind_legal_a: assert final (op_kind inside {
		sp_isa_pkg::OP_NONE, sp_isa_pkg::OP_MPY, sp_isa_pkg::OP_MPYU,
		sp_isa_pkg::OP_MPYH, sp_isa_pkg::OP_MPYA, sp_isa_pkg::OP_MPYI,
		sp_isa_pkg::OP_MPYUI, sp_isa_pkg::OP_FCEQ, sp_isa_pkg::OP_FCGT
	});

endmodule

//--- design/sp_float_compare.sv
`timescale 1ns/100ps

module sp_float_compare (
	input  sp_isa_pkg::sp_op_e op_kind,
	input  sp_pipe_pkg::vec_t  ra,
	input  sp_pipe_pkg::vec_t  rb,
	output sp_pipe_pkg::vec_t  result
);

	localparam int W = sp_pipe_pkg::LANE_W;

	for (genvar i = 0; i < sp_pipe_pkg::LANES; i++) begin : g_lane
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic         both_zero;
		logic         eq;
		logic         gt;
		logic         hit;

		assign a = ra[i*W +: W];
		assign b = rb[i*W +: W];
		assign both_zero = (a[W-2:0] == '0) && (b[W-2:0] == '0);   // +0 and -0
		assign eq = (a == b) || both_zero;

		always_comb begin
			if (both_zero) begin
				gt = 1'b0;
			end else if (a[W-1] != b[W-1]) begin
				gt = !a[W-1];                               // Positive side wins
			end else if (!a[W-1]) begin
				gt = a[W-2:0] > b[W-2:0];
			end else begin
				gt = a[W-2:0] < b[W-2:0];                    // Both negative
			end

			case (op_kind)
				sp_isa_pkg::OP_FCEQ: hit = eq;
				sp_isa_pkg::OP_FCGT: hit = gt;
				default:             hit = 1'b0;
			endcase
		end

		assign result[i*W +: W] = {W{hit}};
	end

endmodule

//--- design/sp_int_mult.sv
`timescale 1ns/100ps

module sp_int_mult (
	input  sp_isa_pkg::sp_op_e op_kind,
	input  sp_pipe_pkg::vec_t  ra,
	input  sp_pipe_pkg::vec_t  rb,
	input  sp_pipe_pkg::vec_t  rc,
	input  sp_isa_pkg::imm_t   imm,
	output sp_pipe_pkg::vec_t  result
);

	localparam int W = sp_pipe_pkg::LANE_W;
	localparam int HALF_W = W / 2;

	logic [HALF_W-1:0] imm_half;
	logic              use_imm;

	assign imm_half = {{(HALF_W - 10){imm[8]}}, imm[8:17]};   // I10 field, sign-extended
	assign use_imm = (op_kind == sp_isa_pkg::OP_MPYI) || (op_kind == sp_isa_pkg::OP_MPYUI);

	for (genvar i = 0; i < sp_pipe_pkg::LANES; i++) begin : g_lane
		logic [HALF_W-1:0]   a_sel;
		logic [HALF_W-1:0]   b_sel;
		logic signed [W-1:0] prod_s;
		logic [W-1:0]        prod_u;
		logic [W-1:0]        lane_res;

		always_comb begin
			if (op_kind == sp_isa_pkg::OP_MPYH) begin
				a_sel = ra[i*W +: HALF_W];               // High halfword of ra
			end else begin
				a_sel = ra[i*W+HALF_W +: HALF_W];
			end
			b_sel = use_imm ? imm_half : rb[i*W+HALF_W +: HALF_W];
			prod_s = $signed(a_sel) * $signed(b_sel);
			prod_u = a_sel * b_sel;

			case (op_kind)
				sp_isa_pkg::OP_MPY,
				sp_isa_pkg::OP_MPYI:  lane_res = prod_s;
				sp_isa_pkg::OP_MPYU,
				sp_isa_pkg::OP_MPYUI: lane_res = prod_u;
				sp_isa_pkg::OP_MPYH:  lane_res = prod_s << HALF_W;
				sp_isa_pkg::OP_MPYA:  lane_res = prod_s + rc[i*W +: W];   // Wraps
				default:              lane_res = '0;
			endcase
		end

		assign result[i*W +: W] = lane_res;
	end

endmodule

//--- design/sp_isa_pkg.sv
package sp_isa_pkg;

	parameter int OPC_W = 11;
	parameter int IMM_W = 18;
	parameter int FMT_W = 3;

	typedef enum logic [FMT_W-1:0] {
		FMT_RR   = 3'd0,
		FMT_RRR  = 3'd1,
		FMT_RI8  = 3'd3,
		FMT_RI10 = 3'd4
	} sp_format_e;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_MPY,
		OP_MPYU,
		OP_MPYH,
		OP_MPYA,
		OP_MPYI,
		OP_MPYUI,
		OP_FCEQ,
		OP_FCGT
	} sp_op_e;

	typedef logic [0:OPC_W-1] opcode_t;
	typedef logic [0:IMM_W-1] imm_t;

	parameter logic [0:10] OPC_MPY  = 11'b01111000100;
	parameter logic [0:10] OPC_MPYU = 11'b01111001100;
	parameter logic [0:10] OPC_MPYH = 11'b01111000101;
	parameter logic [0:10] OPC_FCEQ = 11'b01111000010;
	parameter logic [0:10] OPC_FCGT = 11'b01011000010;

	parameter logic [0:3] OPC_MPYA = 4'b1100;   // Matched against opcode bits 7..10

	parameter logic [0:7] OPC_MPYI  = 8'b01110100;   // Matched against opcode bits 3..10
	parameter logic [0:7] OPC_MPYUI = 8'b01110101;

	function automatic logic is_int_op(input sp_op_e kind);
		return kind inside {OP_MPY, OP_MPYU, OP_MPYH, OP_MPYA, OP_MPYI, OP_MPYUI};
	endfunction

endpackage

//--- design/sp_pipe_pkg.sv
package sp_pipe_pkg;

	parameter int LANE_W = 32;
	parameter int LANES  = 4;
	parameter int VEC_W  = LANE_W * LANES;
	parameter int ADDR_W = 7;

	// Big-endian numbering, lane 0 is bits 0..31
	typedef logic [0:VEC_W-1] vec_t;
	typedef logic [0:ADDR_W-1] reg_addr_t;

	parameter int PIPE_DEPTH = 7;
	parameter int FP_TAP = 5;         // Floating results leave one stage early
	parameter int HAZARD_DEPTH = 6;

endpackage

//--- design/sp_raw_hazard.sv
`timescale 1ns/100ps

module sp_raw_hazard #(
	parameter int HAZARD_DEPTH = sp_pipe_pkg::HAZARD_DEPTH
) (
	input  logic                   clk,
	input  logic                   reset,
	input  sp_pipe_pkg::reg_addr_t rt_addr,
	input  logic                   reg_write,
	input  sp_pipe_pkg::reg_addr_t [HAZARD_DEPTH-1:0] stage_addr,
	input  logic [HAZARD_DEPTH-1:0] stage_write,
	input  sp_pipe_pkg::reg_addr_t ra_addr,
	input  sp_pipe_pkg::reg_addr_t rb_addr,
	input  sp_pipe_pkg::reg_addr_t rc_addr,
	input  logic                   ra_valid,
	input  logic                   rb_valid,
	input  logic                   rc_valid,
	output logic                   stall
);

	logic [HAZARD_DEPTH:0] hit;   // Top bit is the instruction now issuing

	function automatic logic is_read(input sp_pipe_pkg::reg_addr_t addr);
		return (ra_valid && addr == ra_addr) ||
			(rb_valid && addr == rb_addr) ||
			(rc_valid && addr == rc_addr);
	endfunction

	always_comb begin
		hit[HAZARD_DEPTH] = reg_write && is_read(rt_addr);
		for (int i = 0; i < HAZARD_DEPTH; i++) begin
			hit[i] = stage_write[i] && is_read(stage_addr[i]);
		end
	end

	assign stall = !reset && (|hit);

	no_stall_in_reset_a: assert property (@(posedge clk) reset |-> !stall);

endmodule

//--- design/sp_result_pipe.sv
`timescale 1ns/100ps

module sp_result_pipe #(
	parameter int PIPE_DEPTH   = sp_pipe_pkg::PIPE_DEPTH,
	parameter int FP_TAP       = sp_pipe_pkg::FP_TAP,
	parameter int HAZARD_DEPTH = sp_pipe_pkg::HAZARD_DEPTH
) (
	input  logic                   clk,
	input  logic                   reset,
	input  sp_isa_pkg::sp_op_e     op_kind,
	input  sp_pipe_pkg::vec_t      int_result,
	input  sp_pipe_pkg::vec_t      fp_result,
	input  sp_pipe_pkg::reg_addr_t rt_addr,
	input  logic                   reg_write,
	output sp_pipe_pkg::vec_t      rt_wb,
	output sp_pipe_pkg::reg_addr_t rt_addr_wb,
	output logic                   reg_write_wb,
	output sp_pipe_pkg::vec_t      rt_int,
	output sp_pipe_pkg::reg_addr_t rt_addr_int,
	output logic                   reg_write_int,
	output sp_pipe_pkg::reg_addr_t [HAZARD_DEPTH-1:0] stage_addr,
	output logic [HAZARD_DEPTH-1:0] stage_write
);

	localparam int LAST = PIPE_DEPTH - 1;

	sp_pipe_pkg::vec_t      data_q [PIPE_DEPTH];
	sp_pipe_pkg::reg_addr_t addr_q [PIPE_DEPTH];
	logic [PIPE_DEPTH-1:0]  write_q;
	logic [PIPE_DEPTH-1:0]  int_q;
	logic                   is_int;

	assign is_int = sp_isa_pkg::is_int_op(op_kind);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				data_q[i] <= '0;
				addr_q[i] <= '0;
			end
			write_q <= '0;
			int_q <= '0;
		end else begin
			for (int i = 1; i < PIPE_DEPTH; i++) begin
				data_q[i] <= data_q[i-1];
				addr_q[i] <= addr_q[i-1];
				write_q[i] <= write_q[i-1];
				int_q[i] <= int_q[i-1];
			end
			if (op_kind == sp_isa_pkg::OP_NONE) begin   // Killed entry
				data_q[0] <= '0;
				addr_q[0] <= '0;
				write_q[0] <= 1'b0;
				int_q[0] <= 1'b0;
			end else begin
				data_q[0] <= is_int ? int_result : fp_result;
				addr_q[0] <= rt_addr;
				write_q[0] <= reg_write;
				int_q[0] <= is_int;
			end
		end
	end

	always_comb begin
		rt_wb = '0;
		rt_addr_wb = '0;
		reg_write_wb = 1'b0;
		if (!int_q[FP_TAP]) begin
			rt_wb = data_q[FP_TAP];
			rt_addr_wb = addr_q[FP_TAP];
			reg_write_wb = write_q[FP_TAP];
		end

		rt_int = '0;
		rt_addr_int = '0;
		reg_write_int = 1'b0;
		if (int_q[LAST]) begin
			rt_int = data_q[LAST];
			rt_addr_int = addr_q[LAST];
			reg_write_int = write_q[LAST];
		end
	end

	always_comb begin
		for (int i = 0; i < HAZARD_DEPTH; i++) begin
			stage_addr[i] = addr_q[i];
		end
	end

	assign stage_write = write_q[HAZARD_DEPTH-1:0];

	// An entry written back early must not write again at the integer tap
	single_writeback_a: assert property (@(posedge clk) disable iff (reset)
		reg_write_wb |-> ##(LAST - FP_TAP) !reg_write_int);

endmodule

//--- design/sp_top.sv
`timescale 1ns/100ps

module sp_top #(
	parameter int PIPE_DEPTH   = sp_pipe_pkg::PIPE_DEPTH,
	parameter int FP_TAP       = sp_pipe_pkg::FP_TAP,
	parameter int HAZARD_DEPTH = sp_pipe_pkg::HAZARD_DEPTH
) (
	input  logic                   clk,
	input  logic                   reset,
	input  sp_isa_pkg::opcode_t    op,
	input  logic [sp_isa_pkg::FMT_W-1:0] format,
	input  sp_pipe_pkg::reg_addr_t rt_addr,
	input  sp_pipe_pkg::vec_t      ra,
	input  sp_pipe_pkg::vec_t      rb,
	input  sp_pipe_pkg::vec_t      rc,
	input  sp_isa_pkg::imm_t       imm,
	input  logic                   reg_write,
	input  logic                   branch_taken,
	input  sp_pipe_pkg::reg_addr_t ra_odd_addr,
	input  sp_pipe_pkg::reg_addr_t rb_odd_addr,
	input  sp_pipe_pkg::reg_addr_t rc_odd_addr,
	input  logic                   is_ra_odd_valid,
	input  logic                   is_rb_odd_valid,
	input  logic                   is_rc_odd_valid,
	input  sp_pipe_pkg::reg_addr_t ra_even_addr,
	input  sp_pipe_pkg::reg_addr_t rb_even_addr,
	input  sp_pipe_pkg::reg_addr_t rc_even_addr,
	input  logic                   is_ra_even_valid,
	input  logic                   is_rb_even_valid,
	input  logic                   is_rc_even_valid,
	output sp_pipe_pkg::vec_t      rt_wb,
	output sp_pipe_pkg::reg_addr_t rt_addr_wb,
	output logic                   reg_write_wb,
	output sp_pipe_pkg::vec_t      rt_int,
	output sp_pipe_pkg::reg_addr_t rt_addr_int,
	output logic                   reg_write_int,
	output logic                   stall_odd_raw,
	output logic                   stall_even_raw
);

	sp_isa_pkg::sp_op_e     op_kind;
	sp_pipe_pkg::vec_t      int_result;
	sp_pipe_pkg::vec_t      fp_result;
	sp_pipe_pkg::reg_addr_t [HAZARD_DEPTH-1:0] stage_addr;
	logic [HAZARD_DEPTH-1:0] stage_write;

	sp_decode decode_i (
		.op           (op),
		.format       (format),
		.branch_taken (branch_taken),
		.op_kind      (op_kind)
	);

	sp_int_mult int_mult_i (
		.op_kind (op_kind),
		.ra      (ra),
		.rb      (rb),
		.rc      (rc),
		.imm     (imm),
		.result  (int_result)
	);

	sp_float_compare float_compare_i (
		.op_kind (op_kind),
		.ra      (ra),
		.rb      (rb),
		.result  (fp_result)
	);

	sp_result_pipe #(
		.PIPE_DEPTH   (PIPE_DEPTH),
		.FP_TAP       (FP_TAP),
		.HAZARD_DEPTH (HAZARD_DEPTH)
	) result_pipe_i (
		.clk           (clk),
		.reset         (reset),
		.op_kind       (op_kind),
		.int_result    (int_result),
		.fp_result     (fp_result),
		.rt_addr       (rt_addr),
		.reg_write     (reg_write),
		.rt_wb         (rt_wb),
		.rt_addr_wb    (rt_addr_wb),
		.reg_write_wb  (reg_write_wb),
		.rt_int        (rt_int),
		.rt_addr_int   (rt_addr_int),
		.reg_write_int (reg_write_int),
		.stage_addr    (stage_addr),
		.stage_write   (stage_write)
	);

	sp_raw_hazard #(.HAZARD_DEPTH(HAZARD_DEPTH)) odd_hazard_i (
		.clk         (clk),
		.reset       (reset),
		.rt_addr     (rt_addr),
		.reg_write   (reg_write),
		.stage_addr  (stage_addr),
		.stage_write (stage_write),
		.ra_addr     (ra_odd_addr),
		.rb_addr     (rb_odd_addr),
		.rc_addr     (rc_odd_addr),
		.ra_valid    (is_ra_odd_valid),
		.rb_valid    (is_rb_odd_valid),
		.rc_valid    (is_rc_odd_valid),
		.stall       (stall_odd_raw)
	);

	sp_raw_hazard #(.HAZARD_DEPTH(HAZARD_DEPTH)) even_hazard_i (
		.clk         (clk),
		.reset       (reset),
		.rt_addr     (rt_addr),
		.reg_write   (reg_write),
		.stage_addr  (stage_addr),
		.stage_write (stage_write),
		.ra_addr     (ra_even_addr),
		.rb_addr     (rb_even_addr),
		.rc_addr     (rc_even_addr),
		.ra_valid    (is_ra_even_valid),
		.rb_valid    (is_rb_even_valid),
		.rc_valid    (is_rc_even_valid),
		.stall       (stall_even_raw)
	);

endmodule

//--- src.f
design/sp_isa_pkg.sv
design/sp_pipe_pkg.sv
design/sp_decode.sv
design/sp_int_mult.sv
design/sp_float_compare.sv
design/sp_result_pipe.sv
design/sp_raw_hazard.sv
design/sp_top.sv
test/sp_tb.sv

//--- test/sp_tb.sv
`timescale 1ns/100ps

module sp_tb;

	localparam int INT_CASES = 6;
	localparam int FP_CASES = 12;
	localparam int DRAIN = 8;
	localparam int N_TESTS = 6;
	localparam int N_ISSUED = 8 + (6 * INT_CASES + DRAIN) + (FP_CASES + DRAIN) + (4 + DRAIN)
		+ (20 + DRAIN) + (2 * 3 * 3 * (1 + DRAIN));

	logic clk;
	logic reset;
	sp_isa_pkg::opcode_t op;
	logic [2:0] format;
	sp_pipe_pkg::reg_addr_t rt_addr;
	sp_pipe_pkg::vec_t ra, rb, rc;
	sp_isa_pkg::imm_t imm;
	logic reg_write, branch_taken;
	sp_pipe_pkg::reg_addr_t ra_odd_addr, rb_odd_addr, rc_odd_addr;
	logic is_ra_odd_valid, is_rb_odd_valid, is_rc_odd_valid;
	sp_pipe_pkg::reg_addr_t ra_even_addr, rb_even_addr, rc_even_addr;
	logic is_ra_even_valid, is_rb_even_valid, is_rc_even_valid;
	sp_pipe_pkg::vec_t rt_wb, rt_int;
	sp_pipe_pkg::reg_addr_t rt_addr_wb, rt_addr_int;
	logic reg_write_wb, reg_write_int, stall_odd_raw, stall_even_raw;

	int errors = 0;
	int cyc = 0;
	logic check_en = 1'b0;

	// Expected tap contents keyed by the cycle they appear in
	sp_pipe_pkg::vec_t fp_data [int];
	sp_pipe_pkg::reg_addr_t fp_addr [int];
	logic fp_wr [int];
	sp_pipe_pkg::vec_t int_data [int];
	sp_pipe_pkg::reg_addr_t int_addr [int];
	logic int_wr [int];
	sp_pipe_pkg::reg_addr_t pend_addr [int];   // Writing entries keyed by issue cycle

	sp_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	initial begin
		#((N_ISSUED + 20 * N_TESTS) * 20);
		$display("Timeout: the tests did not complete in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic longint order_key(input logic [31:0] v);
		return v[31] ? -longint'(v[30:0]) : longint'(v[30:0]);
	endfunction

	function automatic logic [31:0] lane_model(input sp_isa_pkg::sp_op_e kind,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
		input sp_isa_pkg::imm_t iv);
		logic signed [15:0] i10;
		logic [31:0] res;
		i10 = {{6{iv[8]}}, iv[8:17]};
		case (kind)
			sp_isa_pkg::OP_MPY:   res = int'($signed(a[15:0])) * int'($signed(b[15:0]));
			sp_isa_pkg::OP_MPYU:  res = {16'b0, a[15:0]} * {16'b0, b[15:0]};
			sp_isa_pkg::OP_MPYH:  res = (int'($signed(a[31:16])) * int'($signed(b[15:0]))) << 16;
			sp_isa_pkg::OP_MPYA:  res = int'($signed(a[15:0])) * int'($signed(b[15:0])) + c;
			sp_isa_pkg::OP_MPYI:  res = int'($signed(a[15:0])) * int'(i10);
			sp_isa_pkg::OP_MPYUI: res = {16'b0, a[15:0]} * {16'b0, i10};
			sp_isa_pkg::OP_FCEQ:  res = (a == b || (a[30:0] == 0 && b[30:0] == 0)) ? '1 : '0;
			sp_isa_pkg::OP_FCGT:  res = (order_key(a) > order_key(b)) ? '1 : '0;
			default:              res = '0;
		endcase
		return res;
	endfunction

	function automatic logic stall_model(input sp_pipe_pkg::reg_addr_t a,
		input sp_pipe_pkg::reg_addr_t b, input sp_pipe_pkg::reg_addr_t c,
		input logic va, input logic vb, input logic vc);
		logic s;
		s = reg_write && ((va && rt_addr == a) || (vb && rt_addr == b) || (vc && rt_addr == c));
		for (int k = 1; k <= 6; k++) begin
			if (pend_addr.exists(cyc - k)) begin
				s |= (va && pend_addr[cyc-k] == a) || (vb && pend_addr[cyc-k] == b) ||
					(vc && pend_addr[cyc-k] == c);
			end
		end
		return s;
	endfunction

	// Cycle by cycle comparison of both taps and both stalls
	always @(negedge clk) begin
		if (check_en) begin
			if (fp_wr.exists(cyc)) begin
				check_value("rt_wb", rt_wb, fp_data[cyc]);
				check_value("rt_addr_wb", rt_addr_wb, fp_addr[cyc]);
				check_value("reg_write_wb", reg_write_wb, fp_wr[cyc]);
			end else begin
				check_value("rt_wb", rt_wb, '0);
				check_value("rt_addr_wb", rt_addr_wb, '0);
				check_value("reg_write_wb", reg_write_wb, 1'b0);
			end
			if (int_wr.exists(cyc)) begin
				check_value("rt_int", rt_int, int_data[cyc]);
				check_value("rt_addr_int", rt_addr_int, int_addr[cyc]);
				check_value("reg_write_int", reg_write_int, int_wr[cyc]);
			end else begin
				check_value("rt_int", rt_int, '0);
				check_value("rt_addr_int", rt_addr_int, '0);
				check_value("reg_write_int", reg_write_int, 1'b0);
			end
			check_value("stall_odd_raw", stall_odd_raw, stall_model(ra_odd_addr, rb_odd_addr,
				rc_odd_addr, is_ra_odd_valid, is_rb_odd_valid, is_rc_odd_valid));
			check_value("stall_even_raw", stall_even_raw, stall_model(ra_even_addr,
				rb_even_addr, rc_even_addr, is_ra_even_valid, is_rb_even_valid, is_rc_even_valid));
		end
	end

	// Drives one instruction for the cycle after this edge and records what it must produce
	task automatic issue_raw(input sp_isa_pkg::opcode_t o, input logic [2:0] f, input logic br,
		input sp_isa_pkg::sp_op_e kind, input sp_pipe_pkg::reg_addr_t rt,
		input sp_pipe_pkg::vec_t a, input sp_pipe_pkg::vec_t b, input sp_pipe_pkg::vec_t c,
		input sp_isa_pkg::imm_t iv, input logic wr);
		int n;
		sp_pipe_pkg::vec_t res;
		@(posedge clk);
		n = cyc + 1;
		op <= o;
		format <= f;
		branch_taken <= br;
		rt_addr <= rt;
		ra <= a;
		rb <= b;
		rc <= c;
		imm <= iv;
		reg_write <= wr;
		if (kind != sp_isa_pkg::OP_NONE) begin
			for (int i = 0; i < 4; i++) begin
				res[i*32 +: 32] = lane_model(kind, a[i*32 +: 32], b[i*32 +: 32],
					c[i*32 +: 32], iv);
			end
			if (kind inside {sp_isa_pkg::OP_FCEQ, sp_isa_pkg::OP_FCGT}) begin
				fp_data[n+6] = res;
				fp_addr[n+6] = rt;
				fp_wr[n+6] = wr;
			end else begin
				int_data[n+7] = res;
				int_addr[n+7] = rt;
				int_wr[n+7] = wr;
			end
			if (wr) pend_addr[n] = rt;
		end
	endtask

	task automatic issue_kind(input sp_isa_pkg::sp_op_e kind, input sp_pipe_pkg::reg_addr_t rt,
		input sp_pipe_pkg::vec_t a, input sp_pipe_pkg::vec_t b, input sp_pipe_pkg::vec_t c,
		input sp_isa_pkg::imm_t iv, input logic wr);
		sp_isa_pkg::opcode_t o;
		logic [2:0] f;
		f = sp_isa_pkg::FMT_RR;
		case (kind)
			sp_isa_pkg::OP_MPY:   o = sp_isa_pkg::OPC_MPY;
			sp_isa_pkg::OP_MPYU:  o = sp_isa_pkg::OPC_MPYU;
			sp_isa_pkg::OP_MPYH:  o = sp_isa_pkg::OPC_MPYH;
			sp_isa_pkg::OP_FCEQ:  o = sp_isa_pkg::OPC_FCEQ;
			sp_isa_pkg::OP_FCGT:  o = sp_isa_pkg::OPC_FCGT;
			sp_isa_pkg::OP_MPYA: begin
				o = {7'b0101010, sp_isa_pkg::OPC_MPYA};
				f = sp_isa_pkg::FMT_RRR;
			end
			sp_isa_pkg::OP_MPYI: begin
				o = {3'b010, sp_isa_pkg::OPC_MPYI};
				f = sp_isa_pkg::FMT_RI10;
			end
			default: begin
				o = {3'b010, sp_isa_pkg::OPC_MPYUI};
				f = sp_isa_pkg::FMT_RI10;
			end
		endcase
		issue_raw(o, f, 1'b0, kind, rt, a, b, c, iv, wr);
	endtask

	task automatic issue_nops(input int count);
		repeat (count) issue_raw('0, 3'd0, 1'b0, sp_isa_pkg::OP_NONE, '0, '0, '0, '0, '0, 1'b0);
	endtask

	function automatic sp_pipe_pkg::vec_t rand_vec();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic set_source(input int pipe, input int slot, input sp_pipe_pkg::reg_addr_t a,
		input logic v);
		case ({pipe[0], slot[1:0]})
			3'b000: begin
				ra_odd_addr <= a;
				is_ra_odd_valid <= v;
			end
			3'b001: begin
				rb_odd_addr <= a;
				is_rb_odd_valid <= v;
			end
			3'b010: begin
				rc_odd_addr <= a;
				is_rc_odd_valid <= v;
			end
			3'b100: begin
				ra_even_addr <= a;
				is_ra_even_valid <= v;
			end
			3'b101: begin
				rb_even_addr <= a;
				is_rb_even_valid <= v;
			end
			default: begin
				rc_even_addr <= a;
				is_rc_even_valid <= v;
			end
		endcase
	endtask

	task automatic test_reset();
		issue_nops(8);
	endtask

	task automatic test_int_mult();
		sp_pipe_pkg::vec_t edge_a;
		sp_pipe_pkg::vec_t edge_b;
		edge_a = {32'h00008000, 32'h00007fff, 32'hffffffff, 32'h80008000};
		edge_b = {32'h00008000, 32'h00008000, 32'h00007fff, 32'h0000ffff};
		for (int k = 1; k <= 6; k++) begin
			for (int j = 0; j < INT_CASES - 2; j++) begin
				issue_kind(sp_isa_pkg::sp_op_e'(k), $urandom, rand_vec(), rand_vec(), rand_vec(),
					$urandom, 1'b1);
			end
			issue_kind(sp_isa_pkg::sp_op_e'(k), 7'h11, edge_a, edge_b, edge_a, 18'h00200, 1'b1);
			issue_kind(sp_isa_pkg::sp_op_e'(k), 7'h7f, edge_b, edge_a, '1, 18'h001ff, 1'b1);
		end
		issue_nops(DRAIN);
	endtask

	task automatic test_float_compare();
		sp_pipe_pkg::vec_t fa [3];
		sp_pipe_pkg::vec_t fb [3];
		fa[0] = {32'h3f800000, 32'h40000000, 32'h00000000, 32'hbf800000};
		fb[0] = {32'h3f800000, 32'h3f800000, 32'h80000000, 32'hc0000000};
		fa[1] = {32'hbf800000, 32'h80000000, 32'hc1200000, 32'h7f7fffff};
		fb[1] = {32'h3f800000, 32'h00000000, 32'hc1200000, 32'h00000001};
		fa[2] = {32'h80000001, 32'h3f800001, 32'hc0000000, 32'h00000000};
		fb[2] = {32'h00000001, 32'h3f800000, 32'hbf800000, 32'h00000000};
		for (int s = 0; s < 3; s++) begin
			issue_kind(sp_isa_pkg::OP_FCEQ, $urandom, fa[s], fb[s], '0, '0, 1'b1);
			issue_kind(sp_isa_pkg::OP_FCGT, $urandom, fa[s], fb[s], '0, '0, 1'b1);
			issue_kind(sp_isa_pkg::OP_FCEQ, $urandom, fb[s], fa[s], '0, '0, 1'b1);
			issue_kind(sp_isa_pkg::OP_FCGT, $urandom, fb[s], fa[s], '0, '0, 1'b1);
		end
		issue_nops(DRAIN);
	endtask

	task automatic test_kill();
		issue_raw('0, 3'd0, 1'b0, sp_isa_pkg::OP_NONE, 7'h05, rand_vec(), rand_vec(), '0, '0,
			1'b1);
		issue_raw(sp_isa_pkg::OPC_MPY, 3'd0, 1'b1, sp_isa_pkg::OP_NONE, 7'h06, rand_vec(),
			rand_vec(), '0, '0, 1'b1);
		issue_raw(11'b01011000100, 3'd0, 1'b0, sp_isa_pkg::OP_NONE, 7'h07, rand_vec(),
			rand_vec(), '0, '0, 1'b1);   // Floating add
		issue_raw(11'b01110110000, 3'd3, 1'b0, sp_isa_pkg::OP_NONE, 7'h08, rand_vec(),
			rand_vec(), '0, $urandom, 1'b1);
		issue_nops(DRAIN);
	endtask

	task automatic test_pipeline();
		for (int j = 0; j < 20; j++) begin
			issue_kind(sp_isa_pkg::sp_op_e'($urandom_range(1, 8)), $urandom, rand_vec(),
				rand_vec(), rand_vec(), $urandom, 1'b1);
		end
		issue_nops(DRAIN);
	endtask

	task automatic test_raw_hazard();
		sp_pipe_pkg::reg_addr_t x;
		for (int pipe = 0; pipe < 2; pipe++) begin
			for (int slot = 0; slot < 3; slot++) begin
				for (int mode = 0; mode < 3; mode++) begin
					x = $urandom_range(1, 127);
					issue_kind(sp_isa_pkg::OP_MPY, x, rand_vec(), rand_vec(), '0, '0, mode != 2);
					set_source(pipe, slot, x, mode != 1);   // Mode 1 clears valid, mode 2 the write
					issue_nops(DRAIN);
					set_source(pipe, slot, '0, 1'b0);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'hec1e));
		reset = 1'b1;
		op = '0;
		format = '0;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		rc = '0;
		imm = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		{ra_odd_addr, rb_odd_addr, rc_odd_addr} = '0;
		{is_ra_odd_valid, is_rb_odd_valid, is_rc_odd_valid} = '0;
		{ra_even_addr, rb_even_addr, rc_even_addr} = '0;
		{is_ra_even_valid, is_rb_even_valid, is_rc_even_valid} = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		check_en <= 1'b1;

		test_reset();
		test_int_mult();
		test_float_compare();
		test_kill();
		test_pipeline();
		test_raw_hazard();

		@(posedge clk);
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
